/* fcf_pkg.sv */
package fcf_pkg;

    //////////////////////////////
    // Frame format
    //////////////////////////////

    localparam int unsigned FRAME_BITS = 8;              // Bits per command frame

    // A valid frame is 110x_xxx1, MSB first on the line
    localparam logic [2:0] HEADER_PATTERN = 3'b110;      // Top three bits of a frame

    localparam logic [FRAME_BITS-1:0] IDLE_FRAME = 8'hC1; // Sent in place of a bad frame

    //////////////////////////////
    // Lock tracking
    //////////////////////////////

    localparam int unsigned LOCK_COUNT_BITS = 6;         // Saturating confidence counter

    typedef enum logic
    {
        SEARCH = 1'b0,                                   // No frame phase held
        TRACK  = 1'b1                                    // Frame phase held
    } lock_state_t;

endpackage

/* command_resync.sv */
`timescale 1ns/100ps

module command_resync #(
    parameter int RESYNC_STAGES = 2
)
(
    input  logic fast_clock_in,
    input  logic arstn,
    input  logic command_in,
    output logic resync_command
);

    generate
        if (RESYNC_STAGES == 0)
        begin : g_direct
            assign resync_command = command_in;                  // No stages requested
        end
        else
        begin : g_chain
            logic [RESYNC_STAGES-1:0] chain;

            always_ff @(posedge fast_clock_in or negedge arstn)
            begin
                if (!arstn)
                begin
                    chain <= '0;
                end
                else
                begin
                    chain[0] <= command_in;                      // First stage samples the line
                    for (int i = 1; i < RESYNC_STAGES; i++)
                    begin
                        chain[i] <= chain[i-1];
                    end
                end
            end

            assign resync_command = chain[RESYNC_STAGES-1];      // Last stage
        end
    endgenerate

endmodule

/* frame_aligner.sv */
`timescale 1ns/100ps

module frame_aligner
(
    input  logic                        fast_clock_in,
    input  logic                        arstn,
    input  logic                        resync_command,
    output logic [fcf_pkg::FRAME_BITS:0] frame_window,
    output logic                        frame_strobe,
    output logic                        header_ok,
    output logic                        locked
);

    localparam int PHASE_BITS = $clog2(fcf_pkg::FRAME_BITS);

    fcf_pkg::lock_state_t                lock_state;
    logic [PHASE_BITS-1:0]               bit_ctr;         // Free running frame phase
    logic [PHASE_BITS-1:0]               held_phase;      // Phase at which headers are expected
    logic [fcf_pkg::LOCK_COUNT_BITS-1:0] lock_count;
    logic                                at_phase;

    //////////////////////////////
    // Window and header match
    //////////////////////////////

    assign header_ok = (frame_window[fcf_pkg::FRAME_BITS -: 3] == fcf_pkg::HEADER_PATTERN)
                       && frame_window[1];                // Stop bit of a frame in [8:1]

    assign at_phase     = (bit_ctr == held_phase);
    assign locked       = (lock_state == fcf_pkg::TRACK);
    assign frame_strobe = locked && at_phase;

    always_ff @(posedge fast_clock_in or negedge arstn)
    begin
        if (!arstn)
        begin
            frame_window <= '0;
            bit_ctr      <= '0;
        end
        else
        begin
            frame_window <= {frame_window[fcf_pkg::FRAME_BITS-1:0], resync_command};
            if (bit_ctr == PHASE_BITS'(fcf_pkg::FRAME_BITS - 1))
                bit_ctr <= '0;                                 // Wrap at frame length
            else
                bit_ctr <= bit_ctr + 1'b1;
        end
    end

    //////////////////////////////
    // Lock FSM
    //////////////////////////////

    always_ff @(posedge fast_clock_in or negedge arstn)
    begin
        if (!arstn)
        begin
            lock_state <= fcf_pkg::SEARCH;
            held_phase <= '0;
            lock_count <= '0;
        end
        else
        begin
            case (lock_state)
                fcf_pkg::SEARCH:
                begin
                    if (header_ok)
                    begin
                        held_phase <= bit_ctr;                 // Take this phase as frame start
                        lock_count <= 1;
                        lock_state <= fcf_pkg::TRACK;
                    end
                end
                fcf_pkg::TRACK:
                begin
                    if (at_phase && header_ok)
                    begin
                        if (!(&lock_count))
                            lock_count <= lock_count + 1'b1;   // Saturate at max
                    end
                    else if (at_phase || header_ok)
                    begin
                        lock_count <= lock_count - 1'b1;       // Missing or misplaced header
                        if (lock_count == 1)
                            lock_state <= fcf_pkg::SEARCH;
                    end
                end
                default: lock_state <= fcf_pkg::SEARCH;
            endcase
        end
    end

endmodule

/* frame_repair.sv */
`timescale 1ns/100ps

module frame_repair
(
    input  logic                         fast_clock_in,
    input  logic                         arstn,
    input  logic [fcf_pkg::FRAME_BITS:0] frame_window,
    input  logic                         frame_strobe,
    input  logic                         header_ok,
    input  logic                         enable_cleaning,
    output logic                         command_bit
);

    logic [fcf_pkg::FRAME_BITS-1:0] serializer;
    logic [fcf_pkg::FRAME_BITS-1:0] load_value;
    logic                           inner_header;
    logic                           frame_bad;

    //////////////////////////////
    // Frame check
    //////////////////////////////

    // A header pattern shifted by one or two bits inside the frame marks a slipped stream
    assign inner_header = (frame_window[5:3] == fcf_pkg::HEADER_PATTERN)
                          || (frame_window[4:2] == fcf_pkg::HEADER_PATTERN);

    assign frame_bad  = !header_ok || inner_header;

    assign load_value = (enable_cleaning && frame_bad) ? fcf_pkg::IDLE_FRAME
                                                       : frame_window[fcf_pkg::FRAME_BITS:1];

    //////////////////////////////
    // Serializer
    //////////////////////////////

    always_ff @(posedge fast_clock_in or negedge arstn)
    begin
        if (!arstn)
        begin
            serializer <= '0;
        end
        else if (frame_strobe)
        begin
            serializer <= load_value;                                      // New frame at held phase
        end
        else
        begin
            serializer <= {serializer[fcf_pkg::FRAME_BITS-2:0], 1'b0};     // MSB first, zero fill
        end
    end

    assign command_bit = serializer[fcf_pkg::FRAME_BITS-1];

endmodule

/* lane_driver.sv */
`timescale 1ns/100ps

module lane_driver #(
    parameter int                   NUM_LANES   = 4,
    parameter logic [NUM_LANES-1:0] LANE_INVERT = '0
)
(
    input  logic                 fast_clock_in,
    input  logic                 arstn,
    input  logic                 command_bit,
    output logic [NUM_LANES-1:0] lane_p,
    output logic [NUM_LANES-1:0] lane_n
);

    logic [NUM_LANES-1:0] lane_q;                   // One output flop per lane

    //////////////////////////////
    // Output flops
    //////////////////////////////

    always_ff @(posedge fast_clock_in or negedge arstn)
    begin
        if (!arstn)
        begin
            lane_q <= '0;
        end
        else
        begin
            lane_q <= {NUM_LANES{command_bit}} ^ LANE_INVERT;   // Board polarity swap per lane
        end
    end

    // Differential pair, N leg is always the complement of P
    assign lane_p = lane_q;
    assign lane_n = ~lane_q;

endmodule

/* fast_control_fanout.sv */
`timescale 1ns/100ps

module fast_control_fanout #(
    parameter int                   RESYNC_STAGES = 2,
    parameter int                   NUM_LANES     = 4,
    parameter logic [NUM_LANES-1:0] LANE_INVERT   = '0
)
(
    input  logic                 fast_clock_in,
    input  logic                 arstn,
    input  logic                 fast_command_in,
    input  logic                 enable_cleaning,
    output logic                 locked,
    output logic                 fast_command_out,       // Repaired serial stream
    output logic [NUM_LANES-1:0] lane_p,
    output logic [NUM_LANES-1:0] lane_n
);

    logic                         resync_command;
    logic [fcf_pkg::FRAME_BITS:0] frame_window;
    logic                         frame_strobe;
    logic                         header_ok;

    //////////////////////////////
    // Command path
    //////////////////////////////

    command_resync #(
        .RESYNC_STAGES (RESYNC_STAGES)
    ) command_resync_i (
        .fast_clock_in  (fast_clock_in),
        .arstn          (arstn),
        .command_in     (fast_command_in),
        .resync_command (resync_command)
    );

    frame_aligner frame_aligner_i (
        .fast_clock_in  (fast_clock_in),
        .arstn          (arstn),
        .resync_command (resync_command),
        .frame_window   (frame_window),
        .frame_strobe   (frame_strobe),
        .header_ok      (header_ok),
        .locked         (locked)
    );

    frame_repair frame_repair_i (
        .fast_clock_in   (fast_clock_in),
        .arstn           (arstn),
        .frame_window    (frame_window),
        .frame_strobe    (frame_strobe),
        .header_ok       (header_ok),
        .enable_cleaning (enable_cleaning),
        .command_bit     (fast_command_out)
    );

    lane_driver #(
        .NUM_LANES   (NUM_LANES),
        .LANE_INVERT (LANE_INVERT)
    ) lane_driver_i (
        .fast_clock_in (fast_clock_in),
        .arstn         (arstn),
        .command_bit   (fast_command_out),
        .lane_p        (lane_p),
        .lane_n        (lane_n)
    );

endmodule

/* fast_control_fanout_asserts.sv */
`timescale 1ns/100ps

module fast_control_fanout_asserts #(
    parameter int                   NUM_LANES   = 4,
    parameter logic [NUM_LANES-1:0] LANE_INVERT = '0
)
(
    input logic                         fast_clock_in,
    input logic                         arstn,
    input logic [NUM_LANES-1:0]         lane_p,
    input logic [NUM_LANES-1:0]         lane_n,
    input logic                         fast_command_out,
    input logic                         locked,
    input logic                         frame_strobe,
    input logic                         header_ok,
    input logic                         enable_cleaning,
    input logic [fcf_pkg::FRAME_BITS:0] frame_window
);

    logic [6:0] out_hist;                                    // Recent serial output bits
    logic       clean_load;

    // Bad frame: no header, or header pattern one or two bits lower
    assign clean_load = frame_strobe && enable_cleaning
                        && (!header_ok || frame_window[5:3] == fcf_pkg::HEADER_PATTERN
                            || frame_window[4:2] == fcf_pkg::HEADER_PATTERN);

    always_ff @(posedge fast_clock_in or negedge arstn)
    begin
        if (!arstn)
            out_hist <= '0;
        else
            out_hist <= {out_hist[5:0], fast_command_out};
    end

    //////////////////////////////
    // Properties
    //////////////////////////////

    lane_pair_complement: assert property (@(posedge fast_clock_in) disable iff (!arstn)
        lane_n == ~lane_p) else $error("lane_n is not the complement of lane_p");

    lane_follows_output: assert property (@(posedge fast_clock_in) disable iff (!arstn)
        $past(arstn) |-> lane_p == ($past({NUM_LANES{fast_command_out}}) ^ LANE_INVERT))
        else $error("lane_p does not follow fast_command_out");

    // The held phase comes around no earlier than one cycle after lock is taken
    strobe_needs_lock: assert property (@(posedge fast_clock_in) disable iff (!arstn)
        frame_strobe |-> $past(locked)) else $error("frame_strobe while unlocked");

    idle_substituted: assert property (@(posedge fast_clock_in) disable iff (!arstn)
        $past(clean_load, 8) |-> {out_hist, fast_command_out} == fcf_pkg::IDLE_FRAME)
        else $error("bad frame was not replaced by the idle frame");

endmodule

bind fast_control_fanout fast_control_fanout_asserts #(
    .NUM_LANES   (NUM_LANES),
    .LANE_INVERT (LANE_INVERT)
) fast_control_fanout_asserts_i (
    .fast_clock_in    (fast_clock_in),
    .arstn            (arstn),
    .lane_p           (lane_p),
    .lane_n           (lane_n),
    .fast_command_out (fast_command_out),
    .locked           (locked),
    .frame_strobe     (frame_strobe),
    .header_ok        (header_ok),
    .enable_cleaning  (enable_cleaning),
    .frame_window     (frame_window)
);

/* fast_control_fanout_tb.sv */
`timescale 1ns/100ps

module fast_control_fanout_tb;

    localparam int             NUM_LANES   = 4;
    localparam logic [3:0]     LANE_INVERT = 4'b0101;
    localparam int             LATENCY     = 2 + 11;           // RESYNC_STAGES + 11

    logic                 fast_clock_in;
    logic                 arstn;
    logic                 fast_command_in;
    logic                 enable_cleaning;
    logic                 locked;
    logic                 fast_command_out;
    logic [NUM_LANES-1:0] lane_p;
    logic [NUM_LANES-1:0] lane_n;

    logic [31:0] lfsr_state = 32'h7d37;
    int          cyc = 0;                                   // Posedge index, bumped at negedge
    int          start_q[$];
    logic [7:0]  expect_q[$];
    int          test_q[$];
    logic [7:0]  got;
    int          errors[6];
    int          tests_passed = 0;
    int          tests_failed = 0;
    bit          verdict_done = 0;
    string       test_names[6] = '{"reset", "lock", "passthrough", "repair", "polarity",
                                   "lock_loss"};

    fast_control_fanout #(
        .RESYNC_STAGES (2),
        .NUM_LANES     (NUM_LANES),
        .LANE_INVERT   (LANE_INVERT)
    ) fast_control_fanout_i (
        .fast_clock_in    (fast_clock_in),
        .arstn            (arstn),
        .fast_command_in  (fast_command_in),
        .enable_cleaning  (enable_cleaning),
        .locked           (locked),
        .fast_command_out (fast_command_out),
        .lane_p           (lane_p),
        .lane_n           (lane_n)
    );

    initial
    begin
        fast_clock_in = 1'b0;
        forever #4 fast_clock_in = ~fast_clock_in;
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
    endtask

    // Repair rule: header 110 and stop bit 1 required, no 110 one or two bits lower
    function automatic logic [7:0] repaired_value(input logic [7:0] f, input logic clean);
        logic bad;
        bad = (f[7:5] != 3'b110) || !f[0] || (f[4:2] == 3'b110) || (f[3:1] == 3'b110);
        return (clean && bad) ? 8'hC1 : f;
    endfunction

    task automatic make_frame(input bit allow_bad, output logic [7:0] f);
        logic [7:0] payload;
        logic [7:0] pick;
        take_bits(4, payload);
        f = {3'b110, payload[3:0], 1'b1};
        take_bits(2, pick);
        if (allow_bad && pick[1:0] == 2'b11)
        begin
            take_bits(1, pick);
            if (pick[0])
                f[6] = 1'b0;                                 // Broken header
            else
                f = {3'b110, 3'b110, payload[0], 1'b1};     // False inner header
        end
    endtask

    task automatic send_frame(input logic [7:0] f, input logic clean, input int test_id);
        for (int i = 7; i >= 0; i--)
        begin
            @(posedge fast_clock_in);
            if (i == 7)
            begin
                enable_cleaning <= clean;
                if (test_id >= 0)
                begin
                    start_q.push_back(cyc);
                    expect_q.push_back(repaired_value(f, clean));
                    test_q.push_back(test_id);
                end
            end
            fast_command_in <= f[i];
        end
    endtask

    // Keeps the stream going until every checked frame has left the lanes
    task automatic drain_frames(input logic clean, input int test_id);
        logic [7:0] f;
        int         n;
        n = 0;
        while (start_q.size() > 0 && n < 6)
        begin
            make_frame(0, f);
            send_frame(f, clean, -1);
            n++;
        end
        if (start_q.size() > 0)
        begin
            $display("timeout: checked frames never reached the lanes");
            errors[test_id]++;
        end
    endtask

    task automatic report_test(input int id);
        if (errors[id] == 0)
        begin
            $display("test %s: ok", test_names[id]);
            tests_passed++;
        end
        else
        begin
            $display("test %s: %0d errors", test_names[id], errors[id]);
            tests_failed++;
        end
    endtask

    //////////////////////////////
    // Lane monitor
    //////////////////////////////

    always @(negedge fast_clock_in)
    begin : lane_monitor
        int off;
        if (arstn && start_q.size() > 0)
        begin
            off = cyc - start_q[0] - LATENCY;
            if (off >= 0 && off < 8)
            begin
                got = {got[6:0], lane_p[0] ^ LANE_INVERT[0]};
                if (off == 7)
                begin
                    assert (got == expect_q[0])
                    else
                    begin
                        $display("[FAIL] %s expected %h actual %h",
                                 test_names[test_q[0]], expect_q[0], got);
                        errors[test_q[0]]++;
                    end
                    void'(start_q.pop_front());
                    void'(expect_q.pop_front());
                    void'(test_q.pop_front());
                end
            end
        end
        if (arstn && cyc > 8)
        begin
            assert ((lane_n == ~lane_p) && (((lane_p ^ LANE_INVERT) == '0)
                    || ((lane_p ^ LANE_INVERT) == '1)))
            else
            begin
                $display("lanes disagree in polarity: p %b n %b", lane_p, lane_n);
                errors[4]++;
            end
        end
        cyc++;
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial
    begin
        logic [7:0] f;
        int         n;
        arstn           = 1'b0;
        fast_command_in = 1'b0;
        enable_cleaning = 1'b0;
        repeat (4) @(posedge fast_clock_in);
        arstn <= 1'b1;

        repeat (3) @(posedge fast_clock_in);
        @(negedge fast_clock_in);
        assert (!locked && lane_p == LANE_INVERT && lane_n == ~LANE_INVERT)
        else
        begin
            $display("[FAIL] reset expected locked 0 lanes %b actual %b lanes %b",
                     LANE_INVERT, locked, lane_p);
            errors[0]++;
        end
        report_test(0);

        n = 0;
        while (!locked && n < 16)                            // Lock within 16 frames
        begin
            make_frame(0, f);
            send_frame(f, 1'b0, -1);
            n++;
        end
        assert (locked)
        else
        begin
            $display("locked never rose after 16 valid frames");
            errors[1]++;
        end
        repeat (12)
        begin
            make_frame(0, f);
            send_frame(f, 1'b0, -1);
        end
        report_test(1);

        repeat (24)
        begin
            make_frame(1, f);
            send_frame(f, 1'b0, 2);
        end
        drain_frames(1'b0, 2);
        report_test(2);

        repeat (24)
        begin
            make_frame(1, f);
            send_frame(f, 1'b1, 3);
        end
        drain_frames(1'b1, 3);
        report_test(3);

        @(posedge fast_clock_in);
        fast_command_in <= 1'b0;
        enable_cleaning <= 1'b0;
        n = 0;
        while (locked && n < 80 * 8)                         // 63 frames plus margin
        begin
            @(posedge fast_clock_in);
            n++;
        end
        assert (!locked)
        else
        begin
            $display("locked stayed high with the line held at 0");
            errors[5]++;
        end
        repeat (16)
        begin
            @(negedge fast_clock_in);
            assert (lane_p == LANE_INVERT)
            else
            begin
                $display("[FAIL] lock_loss expected %b actual %b", LANE_INVERT, lane_p);
                errors[5]++;
            end
        end
        report_test(4);
        report_test(5);

        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        verdict_done = 1;
        if (tests_failed == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    final
    begin
        if (!verdict_done)
            $display("sim failed");
    end

endmodule

/* build.f */
fcf_pkg.sv
command_resync.sv
frame_aligner.sv
frame_repair.sv
lane_driver.sv
fast_control_fanout.sv
fast_control_fanout_asserts.sv
fast_control_fanout_tb.sv

/* Makefile */
TOP = fast_control_fanout_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o sim_bin
	./obj_dir/sim_bin | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
